/* Bender.yml */
package:
  name: ipic_master

sources:
  - include_dirs:
      - .
    files:
      - ipic_pkg.sv
      - ipic_engine_if.sv
      - ipic_dispatcher.sv
      - ipic_read_engine.sv
      - ipic_write_engine.sv
      - ipic_master_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_ipic_bus_model.sv
      - tb_ipic_master.sv

/* compile.f */
+incdir+.
ipic_pkg.sv
ipic_engine_if.sv
ipic_dispatcher.sv
ipic_read_engine.sv
ipic_write_engine.sv
ipic_master_top.sv
tb_ipic_bus_model.sv
tb_ipic_master.sv

/* ipic_dispatcher.sv */
`timescale 1ns/1ps

module ipic_dispatcher
    import ipic_pkg::*;
(
    input  logic     clk,
    input  logic     reset_n,
    input  logic     tc_start,
    input  ipic_op_t tc_op,
    input  addr_t    tc_addr,
    input  len_t     tc_length,
    input  data_t    tc_wdata,
    input  logic     dp_start,
    input  ipic_op_t dp_op,
    input  addr_t    dp_addr,
    input  len_t     dp_length,
    input  data_t    dp_wdata,
    output logic     tc_ack,
    output logic     tc_done,
    output logic     dp_ack,
    output logic     dp_done,
    output addr_t    mst_addr,
    output len_t     mst_length,
    output logic     mst_type,
    output logic     mstrd_req,
    output logic     mstwr_req,
    ipic_engine_if.dispatcher rd,
    ipic_engine_if.dispatcher wr
);

    disp_state_t state;
    client_t     owner;
    logic        use_wr;
    ipic_op_t    sel_op;
    logic        sel_rd;
    logic        sel_wr;
    logic        eng_done;
    ipic_op_t    job_op;
    addr_t       job_addr;
    len_t        job_length;
    data_t       job_wdata;

    // tc has priority when both start together
    always_comb begin
        sel_op = tc_start ? tc_op : dp_op;
        sel_rd = 1'b0;
        sel_wr = 1'b0;
        case (sel_op)
            OP_BURST_RD, OP_SINGLE_RD, OP_DESC_CKSUM: sel_rd = 1'b1;
            OP_SINGLE_WR, OP_ZERO_FILL: sel_wr = 1'b1;
            default: sel_rd = 1'b0;
        endcase
    end

    assign eng_done = use_wr ? wr.done : rd.done;

    // ----------------------------------------
    // Arbitration FSM
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (!reset_n) begin
            state    <= DISP_IDLE;
            owner    <= CLIENT_NONE;
            use_wr   <= 1'b0;
            tc_ack   <= 1'b0;
            dp_ack   <= 1'b0;
            tc_done  <= 1'b0;
            dp_done  <= 1'b0;
            rd.start <= 1'b0;
            wr.start <= 1'b0;
        end else begin
            case (state)
                DISP_IDLE: begin
                    if (tc_start || dp_start) begin
                        owner    <= tc_start ? CLIENT_TC : CLIENT_DP;
                        tc_ack   <= tc_start;
                        dp_ack   <= !tc_start;
                        use_wr   <= sel_wr;
                        rd.start <= sel_rd;
                        wr.start <= sel_wr;
                        // Unsupported op skips the engines
                        state    <= (sel_rd || sel_wr) ? DISP_BUSY : DISP_FINISH;
                    end
                end
                DISP_BUSY: begin
                    tc_ack   <= 1'b0;
                    dp_ack   <= 1'b0;
                    rd.start <= 1'b0;
                    wr.start <= 1'b0;
                    if (eng_done) begin
                        tc_done <= (owner == CLIENT_TC);
                        dp_done <= (owner == CLIENT_DP);
                        state   <= DISP_FINISH;
                    end
                end
                DISP_FINISH: begin
                    tc_ack <= 1'b0;
                    dp_ack <= 1'b0;
                    if (tc_done || dp_done) begin
                        tc_done <= 1'b0;
                        dp_done <= 1'b0;
                        owner   <= CLIENT_NONE;
                        state   <= DISP_IDLE;
                    end else begin
                        // No engine ran, so raise done here
                        tc_done <= (owner == CLIENT_TC);
                        dp_done <= (owner == CLIENT_DP);
                    end
                end
                default: state <= DISP_IDLE;
            endcase
        end
    end

    // Job latch
    always_ff @(posedge clk) begin
        if (state == DISP_IDLE && (tc_start || dp_start)) begin
            job_op     <= sel_op;
            job_addr   <= tc_start ? tc_addr : dp_addr;
            job_length <= tc_start ? tc_length : dp_length;
            job_wdata  <= tc_start ? tc_wdata : dp_wdata;
        end
    end

    assign rd.op     = job_op;
    assign rd.addr   = job_addr;
    assign rd.length = job_length;
    assign rd.wdata  = job_wdata;
    assign wr.op     = job_op;
    assign wr.addr   = job_addr;
    assign wr.length = job_length;
    assign wr.wdata  = job_wdata;

    // Shared command port follows the active engine
    assign mstrd_req  = rd.cmd_req;
    assign mstwr_req  = wr.cmd_req;
    assign mst_addr   = use_wr ? wr.cmd_addr : rd.cmd_addr;
    assign mst_length = use_wr ? wr.cmd_length : rd.cmd_length;
    assign mst_type   = use_wr ? wr.cmd_burst : rd.cmd_burst;

endmodule

/* ipic_engine_if.sv */
`timescale 1ns/1ps

interface ipic_engine_if
    import ipic_pkg::*;
();

    // Job from the dispatcher, held until done
    logic     start;
    ipic_op_t op;
    addr_t    addr;
    len_t     length;
    data_t    wdata;

    // Completion and bus command from the engine
    logic     done;
    logic     cmd_req;
    addr_t    cmd_addr;
    len_t     cmd_length;
    logic     cmd_burst;

    modport dispatcher (
        output start, op, addr, length, wdata,
        input  done, cmd_req, cmd_addr, cmd_length, cmd_burst
    );

    modport engine (
        input  start, op, addr, length, wdata,
        output done, cmd_req, cmd_addr, cmd_length, cmd_burst
    );

endinterface

/* ipic_master_top.sv */
`timescale 1ns/1ps

module ipic_master_top
    import ipic_pkg::*;
(
    input  logic      clk,
    input  logic      reset_n,
    // Client ports
    input  logic      tc_start,
    input  ipic_op_t  tc_op,
    input  addr_t     tc_addr,
    input  len_t      tc_length,
    input  data_t     tc_wdata,
    output logic      tc_ack,
    output logic      tc_done,
    input  logic      dp_start,
    input  ipic_op_t  dp_op,
    input  addr_t     dp_addr,
    input  len_t      dp_length,
    input  data_t     dp_wdata,
    output logic      dp_ack,
    output logic      dp_done,
    // Results
    output data_t     single_read_data,
    output cksum_t    ptr_checksum,
    output rcv_addr_t rcv_addr,
    output data_t     rcv_data,
    output logic      rcv_we,
    // IPIC command
    output addr_t     mst_addr,
    output len_t      mst_length,
    output logic      mst_type,
    output logic      mstrd_req,
    output logic      mstwr_req,
    input  logic      cmdack,
    input  logic      cmplt,
    // IPIC read and write LocalLink
    input  data_t     mstrd_d,
    input  logic      mstrd_src_rdy_n,
    output logic      mstrd_dst_rdy_n,
    output data_t     mstwr_d,
    output logic      mstwr_sof_n,
    output logic      mstwr_eof_n,
    output logic      mstwr_src_rdy_n,
    input  logic      mstwr_dst_rdy_n
);

    ipic_engine_if rd_if ();
    ipic_engine_if wr_if ();

    ipic_dispatcher u_dispatcher (.rd(rd_if), .wr(wr_if), .*);

    ipic_read_engine u_read_engine (.job(rd_if), .*);

    ipic_write_engine u_write_engine (.job(wr_if), .*);

endmodule

/* ipic_params.svh */
`ifndef IPIC_PARAMS_SVH
`define IPIC_PARAMS_SVH

// Bus widths
`define IPIC_ADDR_W      32
`define IPIC_DATA_W      32
`define IPIC_LEN_W       12
`define IPIC_BEAT_BYTES  4

// Receive packet memory, 512 words
`define RCV_ADDR_W       9

// Descriptor fetched for the checksum
`define DESC_BYTES       40
`define DESC_BEATS       10

`endif

/* ipic_pkg.sv */
package ipic_pkg;

    `include "ipic_params.svh"

    typedef logic [`IPIC_ADDR_W-1:0] addr_t;
    typedef logic [`IPIC_DATA_W-1:0] data_t;
    typedef logic [`IPIC_LEN_W-1:0]  len_t;
    typedef logic [`IPIC_LEN_W-1:0]  beat_t;
    typedef logic [`RCV_ADDR_W-1:0]  rcv_addr_t;
    typedef logic [15:0]             cksum_t;

    // Codes 1, 6 and 7 are not served
    typedef enum logic [2:0] {
        OP_BURST_RD   = 3'd0,
        OP_SINGLE_RD  = 3'd2,
        OP_SINGLE_WR  = 3'd3,
        OP_ZERO_FILL  = 3'd4,
        OP_DESC_CKSUM = 3'd5
    } ipic_op_t;

    typedef enum logic [1:0] {CLIENT_NONE, CLIENT_TC, CLIENT_DP} client_t;

    typedef enum logic [1:0] {DISP_IDLE, DISP_BUSY, DISP_FINISH} disp_state_t;

    typedef enum logic [2:0] {RD_IDLE, RD_REQ, RD_RECV, RD_WAIT_CMPLT, RD_DONE} rd_state_t;

    typedef enum logic [2:0] {WR_IDLE, WR_REQ, WR_SEND, WR_WAIT_CMPLT, WR_DONE} wr_state_t;

endpackage

/* ipic_read_engine.sv */
`timescale 1ns/1ps
`include "ipic_params.svh"

module ipic_read_engine
    import ipic_pkg::*;
(
    input  logic      clk,
    input  logic      reset_n,
    input  logic      cmdack,
    input  logic      cmplt,
    input  data_t     mstrd_d,
    input  logic      mstrd_src_rdy_n,
    output logic      mstrd_dst_rdy_n,
    output data_t     single_read_data,
    output cksum_t    ptr_checksum,
    output rcv_addr_t rcv_addr,
    output data_t     rcv_data,
    output logic      rcv_we,
    ipic_engine_if.engine job
);

    localparam int BEAT_SHIFT = $clog2(`IPIC_BEAT_BYTES);

    rd_state_t state;
    beat_t     beat_idx;
    beat_t     beat_total;
    data_t     sum;
    logic      all_rx;
    logic      beat_take;
    logic      finish;

    assign all_rx    = (beat_idx == beat_total);
    assign beat_take = !mstrd_dst_rdy_n && !mstrd_src_rdy_n && !all_rx
                       && (state == RD_REQ || state == RD_RECV);
    assign finish    = cmplt && all_rx && (state == RD_RECV || state == RD_WAIT_CMPLT);

    // ----------------------------------------
    // Read FSM
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (!reset_n) begin
            state           <= RD_IDLE;
            job.cmd_req     <= 1'b0;
            job.done        <= 1'b0;
            mstrd_dst_rdy_n <= 1'b1;
            rcv_we          <= 1'b0;
            beat_idx        <= '0;
        end else begin
            job.done <= 1'b0;
            rcv_we   <= beat_take && (job.op == OP_BURST_RD);
            if (beat_take) begin
                beat_idx <= beat_idx + 1'b1;
            end
            if (finish) begin
                job.done        <= 1'b1;
                mstrd_dst_rdy_n <= 1'b1;
                state           <= RD_DONE;
            end else begin
                case (state)
                    RD_IDLE: begin
                        if (job.start) begin
                            job.cmd_req     <= 1'b1;
                            mstrd_dst_rdy_n <= 1'b0;
                            beat_idx        <= '0;
                            state           <= RD_REQ;
                        end
                    end
                    RD_REQ: begin
                        if (cmdack) begin
                            job.cmd_req <= 1'b0;
                            state       <= RD_RECV;
                        end
                    end
                    RD_RECV: begin
                        if (all_rx) begin
                            state <= RD_WAIT_CMPLT;
                        end
                    end
                    RD_DONE: state <= RD_IDLE;
                    default: state <= state;
                endcase
            end
        end
    end

    // Command setup and beat data
    always_ff @(posedge clk) begin
        if (state == RD_IDLE && job.start) begin
            job.cmd_addr <= job.addr;
            sum          <= '0;
            case (job.op)
                OP_SINGLE_RD: begin
                    job.cmd_length <= len_t'(`IPIC_BEAT_BYTES);
                    job.cmd_burst  <= 1'b0;
                    beat_total     <= beat_t'(1);
                end
                OP_DESC_CKSUM: begin
                    job.cmd_length <= len_t'(`DESC_BYTES);
                    job.cmd_burst  <= 1'b1;
                    beat_total     <= beat_t'(`DESC_BEATS);
                end
                default: begin
                    job.cmd_length <= job.length;
                    job.cmd_burst  <= 1'b1;
                    beat_total     <= job.length >> BEAT_SHIFT;
                end
            endcase
        end
        if (beat_take) begin
            rcv_addr <= beat_idx[`RCV_ADDR_W-1:0];
            rcv_data <= mstrd_d;
            sum      <= sum + mstrd_d;
            if (job.op == OP_SINGLE_RD && beat_idx == '0) begin
                single_read_data <= mstrd_d;
            end
        end
        // Fold high half into low half
        if (finish && job.op == OP_DESC_CKSUM) begin
            ptr_checksum <= sum[15:0] + sum[31:16];
        end
    end

endmodule

/* ipic_write_engine.sv */
`timescale 1ns/1ps
`include "ipic_params.svh"

module ipic_write_engine
    import ipic_pkg::*;
(
    input  logic  clk,
    input  logic  reset_n,
    input  logic  cmdack,
    input  logic  cmplt,
    input  logic  mstwr_dst_rdy_n,
    output data_t mstwr_d,
    output logic  mstwr_sof_n,
    output logic  mstwr_eof_n,
    output logic  mstwr_src_rdy_n,
    ipic_engine_if.engine job
);

    localparam int BEAT_SHIFT = $clog2(`IPIC_BEAT_BYTES);

    wr_state_t state;
    beat_t     beat_idx;
    beat_t     beat_total;
    beat_t     start_total;
    logic      beat_xfer;

    assign start_total = (job.op == OP_ZERO_FILL) ? beat_t'(job.length >> BEAT_SHIFT)
                                                  : beat_t'(1);
    // Beat moves only when both sides are ready
    assign beat_xfer   = !mstwr_src_rdy_n && !mstwr_dst_rdy_n;

    // ----------------------------------------
    // Write FSM
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (!reset_n) begin
            state           <= WR_IDLE;
            job.cmd_req     <= 1'b0;
            job.done        <= 1'b0;
            mstwr_sof_n     <= 1'b1;
            mstwr_eof_n     <= 1'b1;
            mstwr_src_rdy_n <= 1'b1;
            beat_idx        <= '0;
        end else begin
            job.done <= 1'b0;
            if (beat_xfer) begin
                beat_idx    <= beat_idx + 1'b1;
                mstwr_sof_n <= 1'b1;
                if (beat_idx == beat_total - 1'b1) begin
                    mstwr_src_rdy_n <= 1'b1;
                    mstwr_eof_n     <= 1'b1;
                end else begin
                    mstwr_eof_n <= !(beat_idx + 1'b1 == beat_total - 1'b1);
                end
            end
            case (state)
                WR_IDLE: begin
                    if (job.start) begin
                        job.cmd_req     <= 1'b1;
                        mstwr_sof_n     <= 1'b0;
                        mstwr_eof_n     <= !(start_total == beat_t'(1));
                        mstwr_src_rdy_n <= 1'b0;
                        beat_idx        <= '0;
                        state           <= WR_REQ;
                    end
                end
                WR_REQ: begin
                    if (cmdack) begin
                        job.cmd_req <= 1'b0;
                        state       <= WR_SEND;
                    end
                end
                WR_SEND: begin
                    // All beats gone once src_rdy_n is back high
                    if (mstwr_src_rdy_n) begin
                        job.done <= cmplt;
                        state    <= cmplt ? WR_DONE : WR_WAIT_CMPLT;
                    end
                end
                WR_WAIT_CMPLT: begin
                    if (cmplt) begin
                        job.done <= 1'b1;
                        state    <= WR_DONE;
                    end
                end
                default: state <= WR_IDLE;
            endcase
        end
    end

    // Command and beat payload
    always_ff @(posedge clk) begin
        if (state == WR_IDLE && job.start) begin
            job.cmd_addr   <= job.addr;
            job.cmd_length <= (job.op == OP_ZERO_FILL) ? job.length : len_t'(`IPIC_BEAT_BYTES);
            job.cmd_burst  <= (job.op == OP_ZERO_FILL);
            beat_total     <= start_total;
            mstwr_d        <= (job.op == OP_SINGLE_WR) ? job.wdata : '0;
        end
    end

endmodule

/* tb_ipic_bus_model.sv */
`timescale 1ns/1ps
`include "ipic_params.svh"

module tb_ipic_bus_model
    import ipic_pkg::*;
(
    input  logic  clk,
    input  logic  reset_n,
    input  addr_t mst_addr,
    input  len_t  mst_length,
    input  logic  mst_type,
    input  logic  mstrd_req,
    input  logic  mstwr_req,
    output logic  cmdack,
    output logic  cmplt,
    output data_t mstrd_d,
    output logic  mstrd_src_rdy_n,
    input  logic  mstrd_dst_rdy_n,
    input  data_t mstwr_d,
    input  logic  mstwr_src_rdy_n,
    output logic  mstwr_dst_rdy_n
);

    localparam int  MEM_WORDS   = 1024;
    localparam time DRIVE_DELAY = 10;

    data_t mem [MEM_WORDS];

    task automatic tick();
        @(posedge clk);
        #DRIVE_DELAY;
    endtask

    // Random wait of 0 to 3 cycles
    task automatic stall();
        int n;
        n = $urandom % 4;
        repeat (n) tick();
    endtask

    initial begin
        int unsigned idx;
        int          beats;
        logic        is_rd;
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i] = (i * 32'h9e37_79b9) ^ 32'h5a5a_0f0f;
        end
        cmdack          = 1'b0;
        cmplt           = 1'b0;
        mstrd_d         = '0;
        mstrd_src_rdy_n = 1'b1;
        mstwr_dst_rdy_n = 1'b1;
        forever begin
            tick();
            if (reset_n && (mstrd_req || mstwr_req)) begin
                is_rd = mstrd_req;
                idx   = mst_addr[11:2];
                beats = mst_type ? int'(mst_length) / `IPIC_BEAT_BYTES : 1;
                stall();
                cmdack = 1'b1;
                tick();
                cmdack = 1'b0;
                for (int k = 0; k < beats; k++) begin
                    stall();
                    if (is_rd) begin
                        mstrd_d         = mem[(idx + k) % MEM_WORDS];
                        mstrd_src_rdy_n = 1'b0;
                        while (mstrd_dst_rdy_n) tick();
                        tick();
                        mstrd_src_rdy_n = 1'b1;
                    end else begin
                        // Beat moves at the next edge once src_rdy_n is low
                        mstwr_dst_rdy_n = 1'b0;
                        while (mstwr_src_rdy_n) tick();
                        mem[(idx + k) % MEM_WORDS] = mstwr_d;
                        tick();
                        mstwr_dst_rdy_n = 1'b1;
                    end
                end
                stall();
                cmplt = 1'b1;
                tick();
                cmplt = 1'b0;
            end
        end
    end

endmodule

/* tb_ipic_master.sv */
`timescale 1ns/1ps
`include "ipic_params.svh"

module tb_ipic_master
    import ipic_pkg::*;
();

    localparam time PERIOD       = 100;
    localparam time DRIVE_DELAY  = 10;
    localparam int  RESET_CYCLES = 8;
    localparam int  NUM_JOBS     = 23;
    localparam int  MEM_WORDS    = 1024;

    logic      clk;
    logic      reset_n;
    logic      tc_start, tc_ack, tc_done;
    ipic_op_t  tc_op;
    addr_t     tc_addr;
    len_t      tc_length;
    data_t     tc_wdata;
    logic      dp_start, dp_ack, dp_done;
    ipic_op_t  dp_op;
    addr_t     dp_addr;
    len_t      dp_length;
    data_t     dp_wdata;
    data_t     single_read_data;
    cksum_t    ptr_checksum;
    rcv_addr_t rcv_addr;
    data_t     rcv_data;
    logic      rcv_we;
    addr_t     mst_addr;
    len_t      mst_length;
    logic      mst_type, mstrd_req, mstwr_req, cmdack, cmplt;
    data_t     mstrd_d, mstwr_d;
    logic      mstrd_src_rdy_n, mstrd_dst_rdy_n;
    logic      mstwr_sof_n, mstwr_eof_n, mstwr_src_rdy_n, mstwr_dst_rdy_n;

    // Reference memory and traffic logs
    data_t ref_mem [MEM_WORDS];
    data_t rcv_mem [512];
    int    rcv_hits [512];
    int    rcv_count;
    data_t wr_data [$];
    logic  wr_sof [$];
    logic  wr_eof [$];
    int    req_count;
    logic  req_seen;
    int    error_count;

    ipic_master_top dut0 (.*);

    tb_ipic_bus_model bus0 (.*);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(NUM_JOBS * 200 * PERIOD);
        $display("Watchdog expired before all jobs finished");
        $display("Some tests failed");
        $fatal(1);
    end

    // Outputs are stable at the falling edge
    always @(negedge clk) begin
        if (reset_n) begin
            if (rcv_we) begin
                rcv_mem[rcv_addr] = rcv_data;
                rcv_hits[rcv_addr]++;
                rcv_count++;
            end
            if (!mstwr_src_rdy_n && !mstwr_dst_rdy_n) begin
                wr_data.push_back(mstwr_d);
                wr_sof.push_back(mstwr_sof_n);
                wr_eof.push_back(mstwr_eof_n);
            end
            if ((mstrd_req || mstwr_req) && !req_seen) begin
                req_count++;
            end
            req_seen = mstrd_req || mstwr_req;
        end
    end

    task automatic report_error(input string msg);
        error_count++;
        $display("error at %0d ns: %s", $time, msg);
        $display("Some tests failed");
        $fatal(1);
    endtask

    task automatic tick();
        @(posedge clk);
        #DRIVE_DELAY;
    endtask

    task automatic clear_log();
        for (int i = 0; i < 512; i++) begin
            rcv_hits[i] = 0;
        end
        rcv_count = 0;
        req_count = 0;
        wr_data.delete();
        wr_sof.delete();
        wr_eof.delete();
    endtask

    task automatic check_idle_outputs();
        assert (!mstrd_req && !mstwr_req && !rcv_we)
            else report_error("request or rcv_we high while idle");
        assert (!tc_ack && !tc_done && !dp_ack && !dp_done)
            else report_error("client handshake high while idle");
        assert (mstrd_dst_rdy_n && mstwr_src_rdy_n && mstwr_sof_n && mstwr_eof_n)
            else report_error("LocalLink control low while idle");
    endtask

    task automatic drive_client(input client_t who, input logic start, input ipic_op_t op,
                                input addr_t addr, input len_t length, input data_t wdata);
        if (who == CLIENT_TC) begin
            tc_start  = start;
            tc_op     = op;
            tc_addr   = addr;
            tc_length = length;
            tc_wdata  = wdata;
        end else begin
            dp_start  = start;
            dp_op     = op;
            dp_addr   = addr;
            dp_length = length;
            dp_wdata  = wdata;
        end
    endtask

    // Dispatcher is idle on entry, so ack must follow in one cycle
    task automatic run_job(input client_t who, input ipic_op_t op, input addr_t addr,
                           input len_t length, input data_t wdata);
        logic done_seen;
        drive_client(who, 1'b1, op, addr, length, wdata);
        tick();
        if (who == CLIENT_TC) begin
            assert (tc_ack && !dp_ack) else report_error("tc_ack not one cycle after start");
        end else begin
            assert (dp_ack && !tc_ack) else report_error("dp_ack not one cycle after start");
        end
        drive_client(who, 1'b0, op, addr, length, wdata);
        done_seen = 1'b0;
        while (!done_seen) begin
            tick();
            assert (!tc_ack && !dp_ack) else report_error("ack repeated during job");
            if (who == CLIENT_TC) begin
                assert (!dp_done) else report_error("dp_done raised for a tc job");
                done_seen = tc_done;
            end else begin
                assert (!tc_done) else report_error("tc_done raised for a dp job");
                done_seen = dp_done;
            end
        end
        tick();
        assert (!tc_done && !dp_done) else report_error("done longer than one cycle");
    endtask

    function automatic int random_beats();
        return 2 + ($urandom % 31);
    endfunction

    function automatic addr_t random_addr(input int beats);
        return addr_t'(($urandom % (MEM_WORDS - beats)) * `IPIC_BEAT_BYTES);
    endfunction

    // ----------------------------------------
    // Scenario tasks
    // ----------------------------------------
    task automatic write_then_read(input addr_t addr, input data_t data);
        clear_log();
        run_job(CLIENT_TC, OP_SINGLE_WR, addr, len_t'(`IPIC_BEAT_BYTES), data);
        assert (req_count == 1 && wr_data.size() == 1) else report_error("single write beats");
        assert (wr_data[0] == data) else report_error("single write data mismatch");
        assert (!wr_sof[0] && !wr_eof[0]) else report_error("single write sof_n/eof_n not low");
        ref_mem[addr >> 2] = data;
        run_job(CLIENT_DP, OP_SINGLE_RD, addr, len_t'(`IPIC_BEAT_BYTES), '0);
        assert (single_read_data == data)
            else report_error($sformatf("read %h, expected %h", single_read_data, data));
    endtask

    task automatic burst_read_check(input addr_t addr, input int beats);
        int base;
        base = int'(addr >> 2);
        clear_log();
        run_job(CLIENT_TC, OP_BURST_RD, addr, len_t'(beats * `IPIC_BEAT_BYTES), '0);
        assert (rcv_count == beats)
            else report_error($sformatf("%0d rcv writes, expected %0d", rcv_count, beats));
        for (int k = 0; k < beats; k++) begin
            assert (rcv_hits[k] == 1)
                else report_error($sformatf("rcv word %0d not written once", k));
            assert (rcv_mem[k] == ref_mem[base + k])
                else report_error($sformatf("rcv word %0d is %h, expected %h",
                                            k, rcv_mem[k], ref_mem[base + k]));
        end
    endtask

    task automatic checksum_check(input addr_t addr);
        data_t  sum;
        cksum_t expected;
        sum = '0;
        for (int k = 0; k < `DESC_BEATS; k++) begin
            sum = sum + ref_mem[int'(addr >> 2) + k];
        end
        expected = sum[15:0] + sum[31:16];
        run_job(CLIENT_DP, OP_DESC_CKSUM, addr, '0, '0);
        assert (ptr_checksum == expected)
            else report_error($sformatf("checksum %h, expected %h", ptr_checksum, expected));
    endtask

    task automatic zero_fill_check(input addr_t addr, input int beats);
        clear_log();
        run_job(CLIENT_TC, OP_ZERO_FILL, addr, len_t'(beats * `IPIC_BEAT_BYTES), '0);
        assert (wr_data.size() == beats) else report_error("zero fill beat count");
        for (int k = 0; k < beats; k++) begin
            assert (wr_data[k] == '0) else report_error($sformatf("zero fill beat %0d not 0", k));
            assert (wr_sof[k] == (k != 0)) else report_error("sof_n wrong on zero fill");
            assert (wr_eof[k] == (k != beats - 1)) else report_error("eof_n wrong on zero fill");
            ref_mem[int'(addr >> 2) + k] = '0;
        end
        burst_read_check(addr, beats);
    endtask

    // tc writes, dp reads the same word in the same cycle
    task automatic simultaneous_check(input addr_t addr, input data_t data);
        drive_client(CLIENT_TC, 1'b1, OP_SINGLE_WR, addr, len_t'(`IPIC_BEAT_BYTES), data);
        drive_client(CLIENT_DP, 1'b1, OP_SINGLE_RD, addr, len_t'(`IPIC_BEAT_BYTES), '0);
        tick();
        assert (tc_ack && !dp_ack) else report_error("tc did not win arbitration");
        tc_start = 1'b0;
        do begin
            tick();
            assert (!dp_ack && !dp_done) else report_error("dp served before tc_done");
        end while (!tc_done);
        ref_mem[addr >> 2] = data;
        do begin
            tick();
            assert (!tc_ack && !tc_done) else report_error("tc handshake during dp wait");
        end while (!dp_ack);
        dp_start = 1'b0;
        do begin
            tick();
            assert (!tc_done) else report_error("tc_done raised for a dp job");
        end while (!dp_done);
        tick();
        assert (single_read_data == data) else report_error("dp read before tc write");
    endtask

    task automatic unsupported_check(input client_t who, input logic [2:0] code);
        clear_log();
        run_job(who, ipic_op_t'(code), random_addr(1), len_t'(16), '0);
        assert (req_count == 0 && wr_data.size() == 0 && rcv_count == 0)
            else report_error($sformatf("bus traffic for unsupported op %0d", code));
    endtask

    initial begin
        int unsigned seed;
        int          beats;
        seed = 32'hb856_1228;
        void'($urandom(seed));
        error_count = 0;
        req_seen    = 1'b0;
        reset_n     = 1'b0;
        drive_client(CLIENT_TC, 1'b0, OP_BURST_RD, '0, '0, '0);
        drive_client(CLIENT_DP, 1'b0, OP_BURST_RD, '0, '0, '0);
        clear_log();
        repeat (RESET_CYCLES) begin
            tick();
            check_idle_outputs();
        end
        reset_n = 1'b1;
        tick();
        check_idle_outputs();
        // Reference starts from the slave's initial contents
        for (int i = 0; i < MEM_WORDS; i++) begin
            ref_mem[i] = bus0.mem[i];
        end

        repeat (4) write_then_read(random_addr(1), $urandom);
        repeat (3) burst_read_check(random_addr(32), random_beats());
        repeat (3) checksum_check(random_addr(`DESC_BEATS));
        repeat (2) begin
            beats = random_beats();
            zero_fill_check(random_addr(beats), beats);
        end
        simultaneous_check(random_addr(1), $urandom);
        unsupported_check(CLIENT_TC, 3'd1);
        unsupported_check(CLIENT_DP, 3'd6);
        unsupported_check(CLIENT_TC, 3'd7);

        if (error_count == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule
